// File: hw/dcache_pkg.sv
package dcache_pkg;

   localparam int PADDR_W     = 15;
   localparam int LINE_BYTES  = 16;
   localparam int LINE_W      = 128;
   localparam int LOAD_W      = 64;
   localparam int OFFSET_W    = 4;
   localparam int BANK_BIT    = 4;
   localparam int SETS        = 8;
   localparam int INDEX_W     = 3;
   localparam int TAG_W       = 7;
   localparam int LINE_ADDR_W = 11;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } req_op_e;

   // Access size in bytes is 1 << size
   typedef enum logic [1:0] {
      SIZE_1 = 2'd0,
      SIZE_2 = 2'd1,
      SIZE_4 = 2'd2,
      SIZE_8 = 2'd3
   } size_e;

   typedef enum logic [1:0] {
      BANK_IDLE  = 2'd0,
      BANK_READ  = 2'd1,
      BANK_WRITE = 2'd2,
      BANK_FILL  = 2'd3
   } bank_op_e;

   typedef struct packed {
      logic                 valid;
      req_op_e              op;
      logic [PADDR_W-1:0]   addr;
      size_e                size;
      logic [LOAD_W-1:0]    wdata;
   } cpu_req_t;

   typedef struct packed {
      logic                   valid;
      logic [LINE_ADDR_W-1:0] line_addr;
      logic [LINE_W-1:0]      data;
   } fill_t;

   // Data is already placed in its byte lanes
   typedef struct packed {
      bank_op_e              op;
      logic [INDEX_W-1:0]    index;
      logic [TAG_W-1:0]      tag;
      logic [LINE_BYTES-1:0] be;
      logic [LINE_W-1:0]     data;
   } bank_req_t;

   typedef struct packed {
      logic              valid;
      logic              hit;
      logic [LINE_W-1:0] data;
   } bank_resp_t;

   typedef struct packed {
      logic                valid;
      req_op_e             op;
      logic [OFFSET_W-1:0] offset;
      size_e               size;
      logic                use_even;
      logic                use_odd;
      logic                first_odd;
   } align_meta_t;

   function automatic logic [3:0] size_bytes(size_e size);
      return 4'd1 << size;
   endfunction

endpackage

// File: hw/access_split.sv
`timescale 1ns/1ps

module access_split
   import dcache_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  cpu_req_t    req_i,
   input  fill_t       fill_i,
   output bank_req_t   even_req_o,
   output bank_req_t   odd_req_o,
   output align_meta_t meta_o
);

   logic [LINE_ADDR_W-1:0]  line0;
   logic [LINE_ADDR_W-1:0]  line1;
   logic [OFFSET_W:0]       end_byte;
   logic                    crossing;
   logic                    first_odd;
   logic [2*LINE_BYTES-1:0] win_be;
   logic [2*LINE_W-1:0]     win_data;
   bank_op_e                first_op;
   bank_op_e                second_op;
   bank_req_t               first_req;
   bank_req_t               second_req;
   bank_req_t               fill_req;
   bank_req_t               even_req_d;
   bank_req_t               odd_req_d;
   align_meta_t             meta_d;

   always_comb begin
      line0     = req_i.addr[PADDR_W-1:OFFSET_W];
      line1     = line0 + 1'b1;
      first_odd = req_i.addr[BANK_BIT];
      end_byte  = {1'b0, req_i.addr[OFFSET_W-1:0]} + {1'b0, size_bytes(req_i.size)};
      crossing  = end_byte > 5'(LINE_BYTES);

      // Byte lanes over the two-line window with the first line in the low half
      win_be   = ((32'd1 << size_bytes(req_i.size)) - 32'd1) << req_i.addr[OFFSET_W-1:0];
      win_data = {192'd0, req_i.wdata} << {req_i.addr[OFFSET_W-1:0], 3'b000};

      first_op  = BANK_IDLE;
      second_op = BANK_IDLE;
      if (req_i.valid) begin
         if (req_i.op == OP_READ) begin
            first_op  = BANK_READ;
            second_op = crossing ? BANK_READ : BANK_IDLE;
         end else if (!crossing) begin
            // Crossing writes are answered as misses
            first_op = BANK_WRITE;
         end
      end

      first_req  = '{op: first_op, index: line0[INDEX_W:1],
                     tag: line0[LINE_ADDR_W-1 -: TAG_W], be: win_be[LINE_BYTES-1:0],
                     data: win_data[LINE_W-1:0]};
      second_req = '{op: second_op, index: line1[INDEX_W:1],
                     tag: line1[LINE_ADDR_W-1 -: TAG_W], be: win_be[2*LINE_BYTES-1:LINE_BYTES],
                     data: win_data[2*LINE_W-1:LINE_W]};
      fill_req   = '{op: BANK_FILL, index: fill_i.line_addr[INDEX_W:1],
                     tag: fill_i.line_addr[LINE_ADDR_W-1 -: TAG_W], be: '1,
                     data: fill_i.data};

      if (fill_i.valid) begin
         even_req_d = fill_i.line_addr[0] ? bank_req_t'('0) : fill_req;
         odd_req_d  = fill_i.line_addr[0] ? fill_req : bank_req_t'('0);
      end else begin
         even_req_d = first_odd ? second_req : first_req;
         odd_req_d  = first_odd ? first_req : second_req;
      end

      meta_d = '{valid: req_i.valid, op: req_i.op, offset: req_i.addr[OFFSET_W-1:0],
                 size: req_i.size, use_even: !first_odd || crossing,
                 use_odd: first_odd || crossing, first_odd: first_odd};
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         even_req_o <= '0;
         odd_req_o  <= '0;
         meta_o     <= '0;
      end else begin
         even_req_o <= even_req_d;
         odd_req_o  <= odd_req_d;
         meta_o     <= meta_d;
      end
   end

endmodule

// File: hw/cache_bank.sv
`timescale 1ns/1ps

module cache_bank
   import dcache_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   input  bank_req_t  req_i,
   output bank_resp_t resp_o
);

   logic [TAG_W-1:0]  tag_q  [SETS];
   logic [LINE_W-1:0] data_q [SETS];
   logic [SETS-1:0]   valid_q;

   logic              hit;
   logic              access;
   logic              resp_valid_q;
   logic              resp_hit_q;
   logic [LINE_W-1:0] resp_data_q;

   // Direct mapped, one line per set
   assign hit    = valid_q[req_i.index] && (tag_q[req_i.index] == req_i.tag);
   assign access = (req_i.op == BANK_READ) || (req_i.op == BANK_WRITE);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q      <= '0;
         resp_valid_q <= 1'b0;
         resp_hit_q   <= 1'b0;
      end else begin
         if (req_i.op == BANK_FILL) begin
            valid_q[req_i.index] <= 1'b1;
         end
         resp_valid_q <= access;
         resp_hit_q   <= access && hit;
      end
   end

   always_ff @(posedge clk) begin
      if (req_i.op == BANK_FILL) begin
         tag_q[req_i.index]  <= req_i.tag;
         data_q[req_i.index] <= req_i.data;
      end else if (req_i.op == BANK_WRITE && hit) begin
         // Merge enabled bytes only
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (req_i.be[b]) begin
               data_q[req_i.index][b*8 +: 8] <= req_i.data[b*8 +: 8];
            end
         end
      end

      if (req_i.op == BANK_READ) begin
         resp_data_q <= data_q[req_i.index];
      end
   end

   assign resp_o = '{valid: resp_valid_q, hit: resp_hit_q, data: resp_data_q};

endmodule

// File: hw/output_align.sv
`timescale 1ns/1ps

module output_align
   import dcache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n_i,
   input  align_meta_t       meta_i,
   input  bank_resp_t        even_resp_i,
   input  bank_resp_t        odd_resp_i,
   output logic              resp_valid_o,
   output logic              resp_hit_o,
   output logic [LOAD_W-1:0] resp_data_o
);

   align_meta_t         meta_q;
   logic [LINE_W-1:0]   first_line;
   logic [LINE_W-1:0]   second_line;
   logic [2*LINE_W-1:0] window;
   logic [LOAD_W-1:0]   shifted;
   logic [LOAD_W-1:0]   size_mask;
   logic                even_ok;
   logic                odd_ok;
   logic                hit;

   always_comb begin
      first_line  = meta_q.first_odd ? odd_resp_i.data : even_resp_i.data;
      second_line = meta_q.first_odd ? even_resp_i.data : odd_resp_i.data;
      window      = {second_line, first_line};
      shifted     = LOAD_W'(window >> {meta_q.offset, 3'b000});

      if (meta_q.size == SIZE_8) begin
         size_mask = '1;
      end else begin
         size_mask = (64'd1 << {size_bytes(meta_q.size), 3'b000}) - 64'd1;
      end

      // An unused bank does not take part in the hit
      even_ok = !meta_q.use_even || (even_resp_i.valid && even_resp_i.hit);
      odd_ok  = !meta_q.use_odd || (odd_resp_i.valid && odd_resp_i.hit);
      hit     = even_ok && odd_ok;
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         meta_q       <= '0;
         resp_valid_o <= 1'b0;
         resp_hit_o   <= 1'b0;
      end else begin
         meta_q       <= meta_i;
         resp_valid_o <= meta_q.valid;
         resp_hit_o   <= meta_q.valid && hit;
      end
   end

   // Loads only carry data
   always_ff @(posedge clk) begin
      if (meta_q.valid && meta_q.op == OP_READ && hit) begin
         resp_data_o <= shifted & size_mask;
      end else begin
         resp_data_o <= '0;
      end
   end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n_i,
   input  cpu_req_t          req_i,
   input  fill_t             fill_i,
   output logic              resp_valid_o,
   output logic              resp_hit_o,
   output logic [LOAD_W-1:0] resp_data_o
);

   bank_req_t   even_req;
   bank_req_t   odd_req;
   bank_resp_t  even_resp;
   bank_resp_t  odd_resp;
   align_meta_t meta;

   access_split split_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .req_i      (req_i),
      .fill_i     (fill_i),
      .even_req_o (even_req),
      .odd_req_o  (odd_req),
      .meta_o     (meta)
   );

   // Even line addresses
   cache_bank bank_even (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (even_req),
      .resp_o  (even_resp)
   );

   // Odd line addresses
   cache_bank bank_odd (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (odd_req),
      .resp_o  (odd_resp)
   );

   output_align align_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .meta_i       (meta),
      .even_resp_i  (even_resp),
      .odd_resp_i   (odd_resp),
      .resp_valid_o (resp_valid_o),
      .resp_hit_o   (resp_hit_o),
      .resp_data_o  (resp_data_o)
   );

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_n_o
);

   // 40 ns period
   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2 rst_n_o = 1'b1;
   end

endmodule

// File: verification/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions
   import dcache_pkg::*;
(
   input logic              clk,
   input logic              rst_n_i,
   input cpu_req_t          req_i,
   input fill_t             fill_i,
   input logic              resp_valid_i,
   input logic [LOAD_W-1:0] resp_data_i
);

   // Response seen at the third edge after the request edge
   latency_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      resp_valid_i == $past(req_i.valid, 3))
      else $error("response latency differs from the request timing");

   no_fill_with_req_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(req_i.valid && fill_i.valid))
      else $error("fill and request strobed in the same cycle");

   known_data_a: assert property (@(posedge clk) disable iff (!rst_n_i)
      resp_valid_i |-> !$isunknown(resp_data_i))
      else $error("response data unknown while valid");

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
   import dcache_pkg::*;
();

   // Request driven after edge k is answered after edge k+3
   localparam int RESP_DELAY    = 3;
   localparam int RESET_CYCLES  = 16;
   localparam int MARGIN_CYCLES = 64;

   typedef struct packed {
      int                due;
      logic              hit;
      logic [LOAD_W-1:0] data;
   } expect_t;

   logic                   clk;
   logic                   rst_n;
   cpu_req_t               req;
   fill_t                  fill;
   logic                   resp_valid;
   logic                   resp_hit;
   logic [LOAD_W-1:0]      resp_data;

   logic [7:0]             ref_bytes [2**PADDR_W];
   logic [LINE_ADDR_W-1:0] slot_line [2*SETS];
   logic                   slot_valid [2*SETS];
   expect_t                pending [$];
   logic [31:0]            lfsr = 32'd91552;
   int                     cycle = 0;
   int                     ops = 0;
   int                     checks = 0;
   int                     test_errors = 0;
   int                     total_errors = 0;
   int                     tests_run = 0;
   int                     tests_failed = 0;
   string                  cur_test = "cold_miss";

   clk_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_i (.clk_o(clk), .rst_n_o(rst_n));

   dcache_top dcache_top_i (
      .clk          (clk),
      .rst_n_i      (rst_n),
      .req_i        (req),
      .fill_i       (fill),
      .resp_valid_o (resp_valid),
      .resp_hit_o   (resp_hit),
      .resp_data_o  (resp_data)
   );

   bind dcache_top dcache_assertions assertions_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i),
      .fill_i       (fill_i),
      .resp_valid_i (resp_valid_o),
      .resp_data_i  (resp_data_o)
   );

   always @(posedge clk) cycle <= cycle + 1;

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [LINE_W-1:0] random_bits(int n);
      logic [LINE_W-1:0] v;
      logic              fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v[i] = fb;
      end
      return v;
   endfunction

   // Slot is bank bit plus set index
   function automatic logic line_hit(logic [LINE_ADDR_W-1:0] line);
      return slot_valid[line[INDEX_W:0]] && slot_line[line[INDEX_W:0]] == line;
   endfunction

   task automatic report_error(input string msg);
      $display("%s", msg);
      test_errors++;
   endtask

   task automatic send_fill(input logic [LINE_ADDR_W-1:0] line);
      logic [LINE_W-1:0] data;
      data = random_bits(LINE_W);
      for (int b = 0; b < LINE_BYTES; b++) begin
         ref_bytes[{line, 4'(b)}] = data[b*8 +: 8];
      end
      slot_line[line[INDEX_W:0]]  = line;
      slot_valid[line[INDEX_W:0]] = 1'b1;
      @(posedge clk);
      #2;
      req  = '0;
      fill = '{valid: 1'b1, line_addr: line, data: data};
      ops++;
   endtask

   task automatic send_req(input req_op_e op, input logic [PADDR_W-1:0] addr,
                           input size_e size, input logic [LOAD_W-1:0] wdata);
      int                     n;
      logic [LINE_ADDR_W-1:0] first;
      logic                   crossing;
      expect_t                e;
      n        = 1 << size;
      first    = addr[PADDR_W-1:OFFSET_W];
      crossing = addr[OFFSET_W-1:0] + n > LINE_BYTES;
      e.data   = '0;
      if (op == OP_READ) begin
         e.hit = line_hit(first) && (!crossing || line_hit(first + 1'b1));
         for (int b = 0; b < n && e.hit; b++) begin
            e.data[b*8 +: 8] = ref_bytes[PADDR_W'(addr + b)];
         end
      end else begin
         // Crossing writes never hit
         e.hit = !crossing && line_hit(first);
         for (int b = 0; b < n && e.hit; b++) begin
            ref_bytes[PADDR_W'(addr + b)] = wdata[b*8 +: 8];
         end
      end
      @(posedge clk);
      #2;
      fill  = '0;
      req   = '{valid: 1'b1, op: op, addr: addr, size: size, wdata: wdata};
      e.due = cycle + RESP_DELAY;
      pending.push_back(e);
      ops++;
   endtask

   task automatic finish_test();
      @(posedge clk);
      #2;
      req  = '0;
      fill = '0;
      while (pending.size() != 0) begin
         @(negedge clk);
      end
      @(negedge clk);
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: passed", cur_test);
      end else begin
         $display("%s: failed with %0d errors", cur_test, test_errors);
         tests_failed++;
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   always @(negedge clk) begin : check_resp
      expect_t e;
      if (!rst_n) begin
         if (resp_valid) begin
            report_error("resp_valid_o went high during reset");
         end
      end else if (pending.size() != 0 && pending[0].due == cycle) begin
         e = pending.pop_front();
         checks++;
         if (!resp_valid) begin
            report_error($sformatf("%s: no response %0d cycles after the request",
                                   cur_test, RESP_DELAY));
         end else begin
            if (resp_hit !== e.hit) begin
               report_error($sformatf("Mismatch %s hit: expected %0b, actual %0b",
                                      cur_test, e.hit, resp_hit));
            end
            if (resp_data !== e.data) begin
               report_error($sformatf("Mismatch %s data: expected %h, actual %h",
                                      cur_test, e.data, resp_data));
            end
         end
      end else if (resp_valid) begin
         report_error($sformatf("%s: response with no request due at cycle %0d",
                                cur_test, cycle));
      end
   end

   always @(negedge clk) begin
      if (cycle > ops * 4 + RESET_CYCLES + MARGIN_CYCLES) begin
         $display("Watchdog timeout at cycle %0d after %0d operations", cycle, ops);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic cold_miss_test();
      cur_test = "cold_miss";
      while (!rst_n) begin
         @(negedge clk);
      end
      send_req(OP_READ, 15'h0000, SIZE_8, '0);
      send_req(OP_READ, 15'h1234, SIZE_4, '0);
      send_req(OP_READ, 15'h7ffc, SIZE_8, '0);
      finish_test();
   endtask

   task automatic fill_read_test();
      logic [LINE_ADDR_W-1:0] lines [2];
      lines    = '{11'h010, 11'h023};
      cur_test = "fill_read";
      send_fill(lines[0]);
      send_fill(lines[1]);
      for (int l = 0; l < 2; l++) begin
         for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < LINE_BYTES; off += 1 << s) begin
               send_req(OP_READ, {lines[l], 4'(off)}, size_e'(s), '0);
            end
         end
      end
      finish_test();
   endtask

   task automatic crossing_read_test();
      cur_test = "crossing_read";
      send_fill(11'h044);
      send_fill(11'h045);
      send_fill(11'h046);
      send_fill(11'h048);
      send_fill(11'h04b);
      send_req(OP_READ, {11'h044, 4'hc}, SIZE_8, '0);
      send_req(OP_READ, {11'h045, 4'hc}, SIZE_8, '0);
      // Next line never filled
      send_req(OP_READ, {11'h048, 4'hc}, SIZE_8, '0);
      send_req(OP_READ, {11'h04b, 4'hc}, SIZE_8, '0);
      finish_test();
   endtask

   task automatic write_test();
      cur_test = "write";
      send_req(OP_WRITE, {11'h010, 4'h4}, SIZE_4, LOAD_W'(random_bits(LOAD_W)));
      send_req(OP_READ, {11'h010, 4'h0}, SIZE_8, '0);
      send_req(OP_READ, {11'h010, 4'h8}, SIZE_8, '0);
      send_req(OP_WRITE, {11'h0ad, 4'h2}, SIZE_2, LOAD_W'(random_bits(LOAD_W)));
      send_req(OP_READ, {11'h0ad, 4'h0}, SIZE_8, '0);
      send_req(OP_WRITE, {11'h044, 4'ha}, SIZE_8, LOAD_W'(random_bits(LOAD_W)));
      send_req(OP_READ, {11'h044, 4'h8}, SIZE_8, '0);
      send_req(OP_READ, {11'h045, 4'h0}, SIZE_8, '0);
      finish_test();
   endtask

   task automatic pipeline_test();
      cur_test = "pipeline";
      for (int i = 0; i < 8; i++) begin
         if (i % 2 == 0) begin
            send_req(OP_READ, {11'h023, 4'h0}, SIZE_8, '0);
         end else begin
            send_req(OP_WRITE, {11'h023, 4'(i)}, size_e'(i % 4),
                     LOAD_W'(random_bits(LOAD_W)));
         end
      end
      send_req(OP_READ, {11'h023, 4'h8}, SIZE_8, '0);
      finish_test();
   endtask

   initial begin
      req  = '0;
      fill = '0;
      for (int s = 0; s < 2*SETS; s++) begin
         slot_valid[s] = 1'b0;
      end
      cold_miss_test();
      fill_read_test();
      crossing_read_test();
      write_test();
      pipeline_test();
      $display("Tests %0d, failed %0d, responses checked %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: dcache.f
hw/dcache_pkg.sv
hw/access_split.sv
hw/cache_bank.sv
hw/output_align.sv
hw/dcache_top.sv
verification/clk_gen.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
